/* hw/sat_pkg.sv */
//**************************************************
// sat_pkg
// shared types and opcode encodings for the
// saturating arithmetic execution unit
//**************************************************
package sat_pkg;

    typedef logic [15:0] word_t;      // data word held in the bank
    typedef logic [3:0]  reg_addr_t;  // register bank address, 16 words
    typedef logic [1:0]  op_code_t;   // alu operation selector

    // operation encodings
    localparam op_code_t OP_ADD  = 2'd0;  // 16-bit saturating add
    localparam op_code_t OP_SUB  = 2'd1;  // 16-bit saturating subtract
    localparam op_code_t OP_PADD = 2'd2;  // four nibble adds, each saturated
    localparam op_code_t OP_RED  = 2'd3;  // 8-bit reduction, sign extended

endpackage

/* hw/adder_cla_4bit.sv */
//**************************************************
// adder_cla_4bit
// 4-bit carry lookahead slice, gives the sum, the
// signed overflow and group propagate / generate
//**************************************************
module adder_cla_4bit (
    input  logic [3:0] a,
    input  logic [3:0] b,
    input  logic       cin,
    output logic [3:0] s,
    output logic       ovfl,        // signed overflow of this slice
    output logic       prop_group,  // slice passes a carry through
    output logic       gen_group    // slice makes a carry by itself
);
    logic [3:0] p;  // bit propagate
    logic [3:0] g;  // bit generate
    logic [4:0] c;  // carry into each bit, c[4] is the carry out

    assign p = a ^ b;
    assign g = a & b;

    // flattened lookahead terms
    assign c[0] = cin;
    assign c[1] = g[0] | (p[0] & cin);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);
    assign c[4] = gen_group | (prop_group & cin);

    assign s = p ^ c[3:0];

    assign ovfl = c[4] ^ c[3];  // carry in and out of the sign bit disagree

    assign prop_group = &p;
    assign gen_group  = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                      | (p[3] & p[2] & p[1] & g[0]);

endmodule

/* hw/adder_multifunc_16bit.sv */
//**************************************************
// adder_multifunc_16bit
// 16-bit saturating add and subtract, four-way
// nibble add and 8-bit reduction, all from seven
// cla slices with rerouted carries
//**************************************************
module adder_multifunc_16bit (
    input  logic           padd,  // four independent nibble adds
    input  logic           red,   // byte reduction
    input  logic           sub,   // a - b, only with 16-bit mode
    input  sat_pkg::word_t a,
    input  sat_pkg::word_t b,     // inverted when subtracting
    output sat_pkg::word_t s,
    output logic           ovfl
);
    import sat_pkg::*;

    word_t       b_flip;    // b after optional inversion
    word_t       s_unsat;   // raw sum of slices 0-3
    word_t       s_padd;    // nibble-saturated sum
    logic [11:0] s_red;     // output of the reduction adder, slices 4-6
    logic [3:0]  nib_ovfl;  // overflow of slices 0-3
    logic [6:0]  cin;       // carry into each slice
    logic [5:0]  cout;      // lookahead carry out, slice 6 not needed
    logic [5:0]  prop;
    logic [5:0]  gen;

    assign b_flip = sub ? ~b : b;  // +1 comes through cin[0]

    // slices 0-3 over the operands, saturated per nibble for padd
    for (genvar i = 0; i < 4; i++) begin : g_nib
        adder_cla_4bit u_nib (
            .a         (a[4*i +: 4]),
            .b         (b_flip[4*i +: 4]),
            .cin       (cin[i]),
            .s         (s_unsat[4*i +: 4]),
            .ovfl      (nib_ovfl[i]),
            .prop_group(prop[i]),
            .gen_group (gen[i])
        );
        assign s_padd[4*i +: 4] = !nib_ovfl[i]    ? s_unsat[4*i +: 4] :
                                  a[4*i + 3]      ? 4'h8 : 4'h7;
    end

    // reduction adder, low nibbles of both byte sums
    adder_cla_4bit u_red_lo (
        .a         (s_unsat[3:0]),
        .b         (s_unsat[11:8]),
        .cin       (cin[4]),
        .s         (s_red[3:0]),
        .ovfl      (),             // reduction never flags overflow
        .prop_group(prop[4]),
        .gen_group (gen[4])
    );

    adder_cla_4bit u_red_hi (
        .a         (s_unsat[7:4]),
        .b         (s_unsat[15:12]),
        .cin       (cin[5]),
        .s         (s_red[7:4]),
        .ovfl      (),
        .prop_group(prop[5]),
        .gen_group (gen[5])
    );

    // carries out of both byte sums land in bits 8 and 9
    adder_cla_4bit u_red_cy (
        .a         ({3'b000, cout[1]}),
        .b         ({3'b000, cout[3]}),
        .cin       (cin[6]),
        .s         (s_red[11:8]),
        .ovfl      (),
        .prop_group(),
        .gen_group ()
    );

    assign cout = gen | (prop & cin[5:0]);

    // carry routing picks 16-bit, two bytes or four nibbles
    assign cin[0] = sub;
    assign cin[1] = padd ? 1'b0 : cout[0];
    assign cin[2] = (padd | red) ? 1'b0 : cout[1];  // byte split for reduction
    assign cin[3] = padd ? 1'b0 : cout[2];
    assign cin[4] = 1'b0;
    assign cin[5] = cout[4];
    assign cin[6] = cout[5];

    assign s = padd        ? s_padd :
               red         ? {{6{s_red[9]}}, s_red[9:0]} :
               !nib_ovfl[3] ? s_unsat :
               a[15]       ? 16'h8000 : 16'h7FFF;  // clamp toward the sign of a

    assign ovfl = padd ? |nib_ovfl :
                  red  ? 1'b0 : nib_ovfl[3];

endmodule

/* hw/alu_sequencer.sv */
//**************************************************
// alu_sequencer
// runs one command: reads rs and rt from the bank,
// feeds the adder and writes the sum back to rd
//**************************************************
module alu_sequencer (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cmd_valid,
    input  sat_pkg::op_code_t cmd_op,
    input  sat_pkg::reg_addr_t cmd_rd,
    input  sat_pkg::reg_addr_t cmd_rs,
    input  sat_pkg::reg_addr_t cmd_rt,
    output logic              busy,
    output logic              done,
    output sat_pkg::word_t    result,
    output logic              result_ovfl,
    output logic              req,        // bank request, held until gnt
    output logic              we,
    output sat_pkg::reg_addr_t addr,
    output sat_pkg::word_t    wdata,
    input  logic              gnt,
    input  logic              rvalid,
    input  sat_pkg::word_t    rdata,
    output logic              padd,       // adder mode controls
    output logic              red,
    output logic              sub,
    output sat_pkg::word_t    opa,
    output sat_pkg::word_t    opb,
    input  sat_pkg::word_t    sum,
    input  logic              sum_ovfl
);
    import sat_pkg::*;

    typedef enum logic [2:0] {
        IDLE, READ_A, WAIT_A, READ_B, WAIT_B, WRITE
    } seq_state_t;

    seq_state_t state;
    op_code_t   op_q;
    reg_addr_t  rd_q, rs_q, rt_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (cmd_valid) begin
                    state <= READ_A;
                    busy  <= 1'b1;
                end
                READ_A: if (gnt)    state <= WAIT_A;
                WAIT_A: if (rvalid) state <= READ_B;
                READ_B: if (gnt)    state <= WAIT_B;
                WAIT_B: if (rvalid) state <= WRITE;
                WRITE: if (gnt) begin       // write accepted, command ends
                    state <= IDLE;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // command fields, operands and result carry no reset
    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_valid) begin
            op_q <= cmd_op;
            rd_q <= cmd_rd;
            rs_q <= cmd_rs;
            rt_q <= cmd_rt;
        end
        if (state == WAIT_A && rvalid) opa <= rdata;
        if (state == WAIT_B && rvalid) opb <= rdata;
        if (state == WRITE && gnt) begin
            result      <= sum;
            result_ovfl <= sum_ovfl;
        end
    end

    assign req   = (state == READ_A) || (state == READ_B) || (state == WRITE);
    assign we    = (state == WRITE);
    assign addr  = (state == READ_A) ? rs_q :
                   (state == READ_B) ? rt_q : rd_q;
    assign wdata = sum;  // adder output goes straight to rd

    // opcode decode
    assign padd = (op_q == OP_PADD);
    assign red  = (op_q == OP_RED);
    assign sub  = (op_q == OP_SUB);

endmodule

/* hw/host_port.sv */
//**************************************************
// host_port
// bank master for the host, holds one request
// until granted and returns the read word
//**************************************************
module host_port (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               host_valid,
    input  logic               host_we,
    input  sat_pkg::reg_addr_t host_addr,
    input  sat_pkg::word_t     host_wdata,
    output logic               host_busy,
    output logic               host_rvalid,
    output sat_pkg::word_t     host_rdata,
    output logic               req,
    output logic               we,
    output sat_pkg::reg_addr_t addr,
    output sat_pkg::word_t     wdata,
    input  logic               gnt,
    input  logic               rvalid,
    input  sat_pkg::word_t     rdata
);
    import sat_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req         <= 1'b0;
            host_busy   <= 1'b0;
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= 1'b0;
            if (host_valid && !host_busy) begin
                req       <= 1'b1;
                host_busy <= 1'b1;
            end else if (req && gnt) begin
                req       <= 1'b0;
                host_busy <= !we;          // a write is finished here
            end else if (host_busy && !req && rvalid) begin
                host_busy   <= 1'b0;
                host_rvalid <= 1'b1;
            end
        end
    end

    // request fields and read data
    always_ff @(posedge clk) begin
        if (host_valid && !host_busy) begin
            we    <= host_we;
            addr  <= host_addr;
            wdata <= host_wdata;
        end
        if (host_busy && !req && rvalid) host_rdata <= rdata;
    end

endmodule

/* hw/bank_arbiter.sv */
//**************************************************
// bank_arbiter
// round robin between sequencer and host for the
// single bank port, read data steered by owner
//**************************************************
module bank_arbiter (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               seq_req,
    input  logic               seq_we,
    input  sat_pkg::reg_addr_t seq_addr,
    input  sat_pkg::word_t     seq_wdata,
    input  logic               host_req,
    input  logic               host_we,
    input  sat_pkg::reg_addr_t host_addr,
    input  sat_pkg::word_t     host_wdata,
    output logic               seq_gnt,
    output logic               host_gnt,
    output logic               seq_rvalid,
    output logic               host_rvalid,
    output sat_pkg::word_t     rdata,
    output logic               bank_en,
    output logic               bank_we,
    output sat_pkg::reg_addr_t bank_addr,
    output sat_pkg::word_t     bank_wdata,
    input  sat_pkg::word_t     bank_rdata
);
    import sat_pkg::*;

    logic last_host;  // host won the previous grant

    // on a tie the master not granted last wins
    assign seq_gnt  = seq_req && (!host_req || last_host);
    assign host_gnt = host_req && (!seq_req || !last_host);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_host   <= 1'b0;
            seq_rvalid  <= 1'b0;
            host_rvalid <= 1'b0;
        end else begin
            if (seq_gnt || host_gnt) last_host <= host_gnt;
            seq_rvalid  <= seq_gnt && !seq_we;    // owner of the read in flight
            host_rvalid <= host_gnt && !host_we;
        end
    end

    assign bank_en    = seq_gnt || host_gnt;
    assign bank_we    = host_gnt ? host_we : (seq_gnt && seq_we);
    assign bank_addr  = host_gnt ? host_addr : seq_addr;
    assign bank_wdata = host_gnt ? host_wdata : seq_wdata;

    assign rdata = bank_rdata;  // shared, qualified by the rvalid pulses

endmodule

/* hw/reg_bank.sv */
//**************************************************
// reg_bank
// single port register bank, registered read
//**************************************************
module reg_bank #(
    parameter int BANK_DEPTH = 16
) (
    input  logic               clk,
    input  logic               en,
    input  logic               we,
    input  sat_pkg::reg_addr_t addr,
    input  sat_pkg::word_t     wdata,
    output sat_pkg::word_t     rdata
);
    import sat_pkg::*;

    word_t mem [BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) mem[addr] <= wdata;
            else    rdata     <= mem[addr];  // one cycle read latency
        end
    end

endmodule

/* hw/sat_alu_top.sv */
//**************************************************
// sat_alu_top
// saturating execution unit: command sequencer and
// host port share the register bank via an arbiter
//**************************************************
module sat_alu_top #(
    parameter int BANK_DEPTH = 16
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cmd_valid,
    input  sat_pkg::op_code_t  cmd_op,
    input  sat_pkg::reg_addr_t cmd_rd,
    input  sat_pkg::reg_addr_t cmd_rs,
    input  sat_pkg::reg_addr_t cmd_rt,
    output logic               busy,
    output logic               done,
    output sat_pkg::word_t     result,
    output logic               result_ovfl,
    input  logic               host_valid,
    input  logic               host_we,
    input  sat_pkg::reg_addr_t host_addr,
    input  sat_pkg::word_t     host_wdata,
    output logic               host_busy,
    output logic               host_rvalid,
    output sat_pkg::word_t     host_rdata
);
    import sat_pkg::*;

    // sequencer side of the arbiter
    logic      seq_req, seq_we, seq_gnt, seq_rvalid;
    reg_addr_t seq_addr;
    word_t     seq_wdata;
    // host port side
    logic      hp_req, hp_we, hp_gnt, hp_rvalid;
    reg_addr_t hp_addr;
    word_t     hp_wdata;
    word_t     rdata;       // shared read return
    // bank port
    logic      bank_en, bank_we;
    reg_addr_t bank_addr;
    word_t     bank_wdata, bank_rdata;
    // adder
    logic      padd, red, sub, sum_ovfl;
    word_t     opa, opb, sum;

    alu_sequencer u_seq (
        .clk(clk), .arst_n(arst_n),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_rd(cmd_rd), .cmd_rs(cmd_rs), .cmd_rt(cmd_rt),
        .busy(busy), .done(done), .result(result), .result_ovfl(result_ovfl),
        .req(seq_req), .we(seq_we), .addr(seq_addr), .wdata(seq_wdata),
        .gnt(seq_gnt), .rvalid(seq_rvalid), .rdata(rdata),
        .padd(padd), .red(red), .sub(sub), .opa(opa), .opb(opb),
        .sum(sum), .sum_ovfl(sum_ovfl)
    );

    host_port u_host (
        .clk(clk), .arst_n(arst_n),
        .host_valid(host_valid), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata),
        .host_busy(host_busy), .host_rvalid(host_rvalid), .host_rdata(host_rdata),
        .req(hp_req), .we(hp_we), .addr(hp_addr), .wdata(hp_wdata),
        .gnt(hp_gnt), .rvalid(hp_rvalid), .rdata(rdata)
    );

    bank_arbiter u_arb (
        .clk(clk), .arst_n(arst_n),
        .seq_req(seq_req), .seq_we(seq_we), .seq_addr(seq_addr), .seq_wdata(seq_wdata),
        .host_req(hp_req), .host_we(hp_we), .host_addr(hp_addr), .host_wdata(hp_wdata),
        .seq_gnt(seq_gnt), .host_gnt(hp_gnt),
        .seq_rvalid(seq_rvalid), .host_rvalid(hp_rvalid), .rdata(rdata),
        .bank_en(bank_en), .bank_we(bank_we),
        .bank_addr(bank_addr), .bank_wdata(bank_wdata), .bank_rdata(bank_rdata)
    );

    reg_bank #(.BANK_DEPTH(BANK_DEPTH)) u_bank (
        .clk(clk), .en(bank_en), .we(bank_we),
        .addr(bank_addr), .wdata(bank_wdata), .rdata(bank_rdata)
    );

    adder_multifunc_16bit u_adder (
        .padd(padd), .red(red), .sub(sub),
        .a(opa), .b(opb), .s(sum), .ovfl(sum_ovfl)
    );

endmodule

/* bench/sat_alu_checker.sv */
//**************************************************
// sat_alu_checker
// bound assertions on the bank arbiter grants, the
// read return timing and the command interface
//**************************************************
module sat_alu_checker (
    input logic clk,
    input logic arst_n,
    input logic seq_gnt,
    input logic seq_we,
    input logic seq_rvalid,
    input logic host_gnt,
    input logic host_we,
    input logic host_rvalid,
    input logic cmd_valid,
    input logic busy
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // read by the testbench at the end of the run

    // one bank port, so one grant per cycle
    a_single_grant: assert property (@(posedge clk) disable iff (!arst_n)
        !(seq_gnt && host_gnt))
        else begin
            $error("sequencer and host granted in the same cycle");
            fail_count++;
        end

    // read data comes back exactly one cycle after a read grant
    a_seq_rvalid: assert property (@(posedge clk) disable iff (!arst_n)
        seq_rvalid == $past(seq_gnt && !seq_we))
        else begin
            $error("sequencer rvalid not one cycle after its read grant");
            fail_count++;
        end

    a_host_rvalid: assert property (@(posedge clk) disable iff (!arst_n)
        host_rvalid == $past(host_gnt && !host_we))
        else begin
            $error("host rvalid not one cycle after its read grant");
            fail_count++;
        end

    a_cmd_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_valid |-> !busy)  // a new command only once the last one is done
        else begin
            $error("cmd_valid arrived while the sequencer was busy");
            fail_count++;
        end

endmodule

// watch the arbiter and sequencer connections inside the top level
bind sat_alu_top sat_alu_checker u_checker (
    .clk(clk), .arst_n(arst_n),
    .seq_gnt(seq_gnt), .seq_we(seq_we), .seq_rvalid(seq_rvalid),
    .host_gnt(hp_gnt), .host_we(hp_we), .host_rvalid(hp_rvalid),
    .cmd_valid(cmd_valid), .busy(busy)
);

/* bench/sat_alu_tb.sv */
//**************************************************
// sat_alu_tb
// replays host writes, host reads and alu commands
// from the stimulus file, adds random host reads
// during commands and checks against a bank model
//**************************************************
module sat_alu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import sat_pkg::*;

    localparam int DEPTH           = 16;
    localparam int CYCLES_PER_LINE = 40;  // watchdog budget per file line
    localparam     INPUT_FILE      = "bench/sat_alu_input.txt";

    logic      clk;
    logic      arst_n;
    logic      cmd_valid;
    op_code_t  cmd_op;
    reg_addr_t cmd_rd, cmd_rs, cmd_rt;
    logic      busy, done;
    word_t     result;
    logic      result_ovfl;
    logic      host_valid, host_we;
    reg_addr_t host_addr;
    word_t     host_wdata;
    logic      host_busy, host_rvalid;
    word_t     host_rdata;

    word_t  bank_model [DEPTH];  // expected bank contents
    logic   known [DEPTH];       // word written at least once
    integer seed = 90;
    int     timeout_cycles = 0;  // set once the file is counted

    sat_alu_top #(.BANK_DEPTH(DEPTH)) DUT (
        .clk(clk), .arst_n(arst_n),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_rd(cmd_rd), .cmd_rs(cmd_rs), .cmd_rt(cmd_rt),
        .busy(busy), .done(done), .result(result), .result_ovfl(result_ovfl),
        .host_valid(host_valid), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata),
        .host_busy(host_busy), .host_rvalid(host_rvalid), .host_rdata(host_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 100 MHz
    end

    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped answering",
                 timeout_cycles);
        stop_with_failure();
    end

    task automatic stop_with_failure;
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic reject_record(input logic [7:0] kind);
        $display("malformed %c record in %s", kind, INPUT_FILE);
        stop_with_failure();
    endtask

    // next rising edge, then 1 ns for driving and sampling
    task automatic step;
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s gave %b, expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic host_write(input reg_addr_t a, input word_t d);
        host_valid = 1'b1;
        host_we    = 1'b1;
        host_addr  = a;
        host_wdata = d;
        step();
        host_valid = 1'b0;
        check_flag(host_busy, 1'b1, "host_busy after a write request");
        while (host_busy) step();  // busy drops once the write is granted
        bank_model[a] = d;
        known[a]      = 1'b1;
    endtask

    task automatic host_read(input reg_addr_t a, input word_t exp, input string what);
        host_valid = 1'b1;
        host_we    = 1'b0;
        host_addr  = a;
        step();
        host_valid = 1'b0;
        check_flag(host_busy, 1'b1, "host_busy after a read request");
        do step(); while (!host_rvalid);
        check_word(host_rdata, exp, what);
    endtask

    task automatic run_command(input op_code_t op, input reg_addr_t rd, input reg_addr_t rs,
                               input reg_addr_t rt, input word_t exp, input logic exp_ovfl);
        int        n_reads;
        reg_addr_t ra;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_rd    = rd;
        cmd_rs    = rs;
        cmd_rt    = rt;
        step();
        cmd_valid = 1'b0;
        check_flag(busy, 1'b1, "busy after cmd_valid");
        n_reads   = 1 + ($random(seed) & 1);
        fork
            // busy stays up and falls together with done
            do begin
                step();
                check_flag(busy, !done, "busy while the command runs");
            end while (!done);
            // host traffic competing for the bank, rd left alone
            for (int i = 0; i < n_reads; i++) begin
                ra = $random(seed);
                if (known[ra] && ra != rd)
                    host_read(ra, bank_model[ra],
                              $sformatf("host read of r%0d during a command", ra));
            end
        join
        check_word(result, exp, $sformatf("command %0d into r%0d", op, rd));
        check_flag(result_ovfl, exp_ovfl, $sformatf("overflow of command %0d", op));
        bank_model[rd] = exp;
        known[rd]      = 1'b1;
    endtask

    initial begin
        integer           fd, code, n_lines;
        logic [7:0]       kind;        // first character of a record
        logic [8*128-1:0] text;
        op_code_t         f_op;
        reg_addr_t        f_addr, f_rd, f_rs, f_rt;
        word_t            f_data;
        logic             f_ovfl;
        arst_n     = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = OP_ADD;
        cmd_rd     = '0;
        cmd_rs     = '0;
        cmd_rt     = '0;
        host_valid = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        for (int i = 0; i < DEPTH; i++) known[i] = 1'b0;

        // count lines first, the watchdog budget scales with them
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s for reading", INPUT_FILE);
            stop_with_failure();
        end
        n_lines = 0;
        while ($fgets(text, fd) != 0) n_lines++;
        $fclose(fd);
        timeout_cycles = n_lines * CYCLES_PER_LINE;

        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;

        fd = $fopen(INPUT_FILE, "r");
        while ($fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": code = $fgets(text, fd);  // comment, rest of line dropped
                "W": begin
                    code = $fscanf(fd, "%h %h", f_addr, f_data);
                    if (code != 2) reject_record(kind);
                    host_write(f_addr, f_data);
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", f_addr, f_data);
                    if (code != 2) reject_record(kind);
                    host_read(f_addr, f_data, $sformatf("host read of r%0d", f_addr));
                end
                "C": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h",
                                   f_op, f_rd, f_rs, f_rt, f_data, f_ovfl);
                    if (code != 6) reject_record(kind);
                    run_command(f_op, f_rd, f_rs, f_rt, f_data, f_ovfl);
                end
                default: begin
                    $display("unknown record type '%c' in %s", kind, INPUT_FILE);
                    stop_with_failure();
                end
            endcase
        end
        $fclose(fd);
        repeat (2) step();  // let the checker see the last cycles

        if (DUT.u_checker.fail_count != 0) begin
            $display("%0d assertion failures seen by the checker",
                     DUT.u_checker.fail_count);
            stop_with_failure();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* bench/sat_alu_input.txt */
# W addr data | R addr expected | C op rd rs rt expected ovfl, all hex
# op 0 add, 1 sub, 2 nibble add, 3 byte reduction
W 0 1234
W 1 0111
W 2 7000
W 3 2000
W 4 8000
W 5 0001
W 6 7654
W 7 31F2
W 8 FFFF
R 0 1234
R 7 31F2
C 0 9 0 1 1345 0
C 0 A 2 3 7FFF 1
C 1 B 4 5 8000 1
C 1 C 0 1 1123 0
C 2 D 6 7 7746 1
C 2 E 0 1 1345 0
C 3 F 8 8 FFFC 0
C 3 E 6 7 01ED 0
C 0 9 9 8 1344 0
R 9 1344
R A 7FFF
R F FFFC

/* sat_alu_top.f */
hw/sat_pkg.sv
hw/adder_cla_4bit.sv
hw/adder_multifunc_16bit.sv
hw/alu_sequencer.sv
hw/host_port.sv
hw/bank_arbiter.sv
hw/reg_bank.sv
hw/sat_alu_top.sv
bench/sat_alu_checker.sv
bench/sat_alu_tb.sv
